// File: Bender.yml
package:
  name: mips_core

sources:
  - files:
      - hdl/mips_pkg.sv
      - hdl/instr_decoder.sv
      - hdl/gp_regfile.sv
      - hdl/exec_unit.sv
      - hdl/pc_unit.sv
      - hdl/mips_core.sv
  - target: test
    files:
      - dv/core_tb.sv

// File: dv/core_tb.sv
module core_tb
    import mips_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] next_pc;
        logic        we;
        logic [4:0]  wd;
        logic [31:0] wval;
        logic        wren;
        logic [31:0] addr;
        logic [31:0] wdata;
    } step_t;

    logic        clk;
    logic        arst_n;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_wren;
    logic [31:0] mem_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    logic [31:0] m_pc;
    logic [31:0] m_regs [32];
    logic [31:0] m_dmem [256];
    step_t       exp_step;

    logic [31:0] lcg_state = 32'h3dd3b1ee;
    int          prog_len = 0;
    int          store_slot = 0;
    logic [31:0] loop_pc;
    int          cycle_cnt = 0;
    int          timeout_limit;

    mips_core i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .pc        (pc),
        .instr     (instr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wren  (mem_wren),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Word addressed, both answer in the same cycle
    assign instr     = imem[pc[9:2]];
    assign mem_rdata = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_wren) begin
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(1 + (lcg_next() >> 8) % 15);
    endfunction

    function automatic logic [31:0] r_word(input funct_e fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sa);
        return {OP_RTYPE, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_word(input opcode_e op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_word(input opcode_e op, input logic [31:0] addr);
        return {op, addr[27:2]};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic emit_marker();
        emit(i_word(OP_ADDIU, 5'd20, 5'd20, 16'd1)); // Counts fall-through paths
    endtask

    task automatic store_reg(input logic [4:0] r);
        emit(i_word(OP_SW, 5'd0, r, 16'(4 * store_slot)));
        store_slot++;
    endtask

    task automatic load_const(input logic [4:0] r, input logic [31:0] value);
        emit(i_word(OP_LUI, 5'd0, r, value[31:16]));
        emit(i_word(OP_ORI, r, r, value[15:0]));
    endtask

    task automatic build_program();
        funct_e      r_ops [13] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                                    FN_NOR, FN_SLT, FN_SLTU, FN_SLLV, FN_SRLV, FN_SRAV};
        funct_e      sh_ops [3] = '{FN_SLL, FN_SRL, FN_SRA};
        opcode_e     i_ops [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                   OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        opcode_e     br_ops [5] = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM};
        opcode_e     bop;
        logic [4:0]  rd;
        logic [31:0] rnd;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int r = 1; r <= 8; r++) begin
            load_const(5'(r), lcg_next());
        end
        load_const(5'd21, (lcg_next() & 32'h7fff_ffff) | 32'h1); // Strictly positive
        load_const(5'd22, lcg_next() | 32'h8000_0000);
        for (int round = 0; round < 3; round++) begin
            foreach (r_ops[k]) begin
                rd = 5'(10 + (lcg_next() >> 8) % 6);
                emit(r_word(r_ops[k], rand_reg(), rand_reg(), rd, 5'd0));
                store_reg(rd);
            end
            foreach (sh_ops[k]) begin
                rd = 5'(10 + (lcg_next() >> 8) % 6);
                emit(r_word(sh_ops[k], 5'd0, rand_reg(), rd, 5'(lcg_next() >> 11)));
                store_reg(rd);
            end
            foreach (i_ops[k]) begin
                rd = 5'(10 + (lcg_next() >> 8) % 6);
                emit(i_word(i_ops[k], rand_reg(), rd, 16'(lcg_next() >> 9)));
                store_reg(rd);
            end
            rnd = lcg_next();
            bop = br_ops[(rnd >> 8) % 5];
            if (bop == OP_BEQ || bop == OP_BNE) begin
                emit(i_word(bop, rand_reg(), rand_reg(), 16'd1));
            end else begin
                emit(i_word(bop, rand_reg(), 5'(rnd[20]), 16'd1));
            end
            emit_marker();
        end
        for (int k = 0; k < 3; k++) begin
            emit(i_word(OP_LW, 5'd0, 5'd12, 16'(4 * ((lcg_next() >> 8) % store_slot))));
            store_reg(5'd12);
        end
        emit(i_word(OP_LW, 5'd0, 5'd12, 16'd800)); // Never stored to
        store_reg(5'd12);

        // Each condition taken, then not taken
        emit(i_word(OP_BEQ, 5'd1, 5'd1, 16'd1));
        emit_marker();
        emit(i_word(OP_BEQ, 5'd21, 5'd22, 16'd1));
        emit_marker();
        emit(i_word(OP_BNE, 5'd21, 5'd22, 16'd1));
        emit_marker();
        emit(i_word(OP_BNE, 5'd1, 5'd1, 16'd1));
        emit_marker();
        emit(i_word(OP_BLEZ, 5'd22, 5'd0, 16'd1));
        emit_marker();
        emit(i_word(OP_BLEZ, 5'd0, 5'd0, 16'd1));
        emit_marker();
        emit(i_word(OP_BLEZ, 5'd21, 5'd0, 16'd1));
        emit_marker();
        emit(i_word(OP_BGTZ, 5'd21, 5'd0, 16'd1));
        emit_marker();
        emit(i_word(OP_BGTZ, 5'd0, 5'd0, 16'd1));
        emit_marker();
        emit(i_word(OP_REGIMM, 5'd22, 5'd0, 16'd1)); // bltz
        emit_marker();
        emit(i_word(OP_REGIMM, 5'd0, 5'd0, 16'd1));
        emit_marker();
        emit(i_word(OP_REGIMM, 5'd0, 5'd1, 16'd1)); // bgez
        emit_marker();
        emit(i_word(OP_REGIMM, 5'd22, 5'd1, 16'd1));
        emit_marker();
        store_reg(5'd20);

        emit(j_word(OP_J, 32'(4 * (prog_len + 2))));
        emit_marker();
        emit(j_word(OP_JAL, 32'(4 * (prog_len + 2))));
        emit_marker();
        store_reg(5'd31);
        emit(i_word(OP_ADDIU, 5'd0, 5'd23, 16'(4 * (prog_len + 3))));
        emit(r_word(FN_JR, 5'd23, 5'd0, 5'd0, 5'd0));
        emit_marker();
        emit(i_word(OP_ADDIU, 5'd0, 5'd23, 16'(4 * (prog_len + 3))));
        emit(r_word(FN_JALR, 5'd23, 5'd0, 5'd24, 5'd0));
        emit_marker();
        store_reg(5'd24);
        store_reg(5'd20);

        emit(i_word(OP_ADDIU, 5'd0, 5'd0, 16'h1234));
        emit(r_word(FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
        store_reg(5'd0);

        loop_pc = 32'(4 * prog_len);
        emit(j_word(OP_J, loop_pc));
    endtask

    // Instruction-set model, one instruction per call
    function automatic step_t model_step(input logic [31:0] w, input logic [31:0] cur_pc);
        step_t       s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] link;
        logic [31:0] ea;
        logic        take;
        a    = m_regs[w[25:21]];
        b    = m_regs[w[20:16]];
        simm = {{16{w[15]}}, w[15:0]};
        zimm = {16'h0000, w[15:0]};
        link = cur_pc + 32'd4;
        ea   = a + simm;
        take = 1'b0;
        s    = '0;
        s.next_pc = link;
        case (w[31:26])
            OP_RTYPE: begin
                s.we = 1'b1;
                s.wd = w[15:11];
                case (w[5:0])
                    FN_ADD, FN_ADDU: s.wval = a + b;
                    FN_SUB, FN_SUBU: s.wval = a - b;
                    FN_AND:  s.wval = a & b;
                    FN_OR:   s.wval = a | b;
                    FN_XOR:  s.wval = a ^ b;
                    FN_NOR:  s.wval = ~(a | b);
                    FN_SLT:  s.wval = 32'($signed(a) < $signed(b));
                    FN_SLTU: s.wval = 32'(a < b);
                    FN_SLL:  s.wval = b << w[10:6];
                    FN_SRL:  s.wval = b >> w[10:6];
                    FN_SRA:  s.wval = $signed(b) >>> w[10:6];
                    FN_SLLV: s.wval = b << a[4:0];
                    FN_SRLV: s.wval = b >> a[4:0];
                    FN_SRAV: s.wval = $signed(b) >>> a[4:0];
                    FN_JR: begin
                        s.we      = 1'b0;
                        s.next_pc = a;
                    end
                    FN_JALR: begin
                        s.wval    = link;
                        s.next_pc = a;
                    end
                    default: s.we = 1'b0;
                endcase
            end
            OP_REGIMM: take = w[16] ? !a[31] : a[31];
            OP_BEQ:    take = (a == b);
            OP_BNE:    take = (a != b);
            OP_BLEZ:   take = ($signed(a) <= 0);
            OP_BGTZ:   take = ($signed(a) > 0);
            OP_J:      s.next_pc = {link[31:28], w[25:0], 2'b00};
            OP_JAL: begin
                s.next_pc = {link[31:28], w[25:0], 2'b00};
                s.we      = 1'b1;
                s.wd      = 5'd31;
                s.wval    = link;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                s.we = 1'b1;
                s.wd = w[20:16];
                case (w[31:26])
                    OP_SLTI:  s.wval = 32'($signed(a) < $signed(simm));
                    OP_SLTIU: s.wval = 32'(a < simm);
                    OP_ANDI:  s.wval = a & zimm;
                    OP_ORI:   s.wval = a | zimm;
                    OP_XORI:  s.wval = a ^ zimm;
                    OP_LUI:   s.wval = {w[15:0], 16'h0000};
                    default:  s.wval = ea;
                endcase
            end
            OP_LW: begin
                s.we   = 1'b1;
                s.wd   = w[20:16];
                s.wval = m_dmem[ea[9:2]];
            end
            OP_SW: begin
                s.wren  = 1'b1;
                s.addr  = ea;
                s.wdata = b;
            end
            default: ;
        endcase
        if (take) begin
            s.next_pc = link + (simm << 2);
        end
        return s;
    endfunction

    always @(negedge clk) begin
        exp_step <= model_step(instr, m_pc);
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_pc <= RESET_PC;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] <= '0;
            end
        end else begin
            m_pc <= exp_step.next_pc;
            if (exp_step.we && exp_step.wd != 5'd0) begin
                m_regs[exp_step.wd] <= exp_step.wval;
            end
            if (exp_step.wren) begin
                m_dmem[exp_step.addr[9:2]] <= exp_step.wdata;
            end
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    a_reset_pc: assert property (@(posedge clk)
        ((!arst_n && cycle_cnt != 0) || $rose(arst_n)) |-> pc == RESET_PC)
        else stop_with_failure($sformatf("mismatch pc: dut=0x%h expected=0x%h",
                                         $sampled(pc), RESET_PC));

    a_pc: assert property (@(posedge clk) disable iff (!arst_n) pc == m_pc)
        else stop_with_failure($sformatf("mismatch pc: dut=0x%h expected=0x%h",
                                         $sampled(pc), $sampled(m_pc)));

    a_wren: assert property (@(posedge clk) disable iff (!arst_n) mem_wren == exp_step.wren)
        else stop_with_failure($sformatf("mismatch mem_wren: dut=0x%h expected=0x%h",
                                         $sampled(mem_wren), $sampled(exp_step.wren)));

    a_addr: assert property (@(posedge clk) disable iff (!arst_n)
        exp_step.wren |-> mem_addr == exp_step.addr)
        else stop_with_failure($sformatf("mismatch mem_addr: dut=0x%h expected=0x%h",
                                         $sampled(mem_addr), $sampled(exp_step.addr)));

    a_wdata: assert property (@(posedge clk) disable iff (!arst_n)
        exp_step.wren |-> mem_wdata == exp_step.wdata)
        else stop_with_failure($sformatf("mismatch mem_wdata: dut=0x%h expected=0x%h",
                                         $sampled(mem_wdata), $sampled(exp_step.wdata)));

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles, final loop never reached",
                                        cycle_cnt));
        end
    end

    initial begin
        arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            dmem[i]   = fill_word(i);
            m_dmem[i] = fill_word(i);
        end
        build_program();
        timeout_limit = 10 + 2 * prog_len + 50;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        while (pc !== loop_pc) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk); // A few laps of the self-loop
        if (pc === loop_pc && m_pc === loop_pc) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_with_failure("the core left the final loop");
        end
    end

endmodule

// File: hdl/exec_unit.sv
module exec_unit
    import mips_pkg::*;
(
    input  ctrl_t           ctrl,
    input  logic [15:0]     imm,
    input  logic [4:0]      sa,
    input  logic [XLEN-1:0] rs_data,
    input  logic [XLEN-1:0] rt_data,
    input  logic [XLEN-1:0] pc_plus4,
    input  logic [XLEN-1:0] mem_rdata,
    output logic [XLEN-1:0] wb_data,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] mem_wdata,
    output logic            branch_taken
);

    logic [XLEN-1:0] imm_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] sh_res;
    logic [4:0]      sh_amt;
    logic            lt_s;
    logic            lt_u;

    assign imm_val = (ctrl.imm_ext == IMM_ZERO) ? {16'h0000, imm} : {{(XLEN-16){imm[15]}}, imm};
    assign op_b    = ctrl.use_imm ? imm_val : rt_data;

    assign sum  = rs_data + op_b;
    assign lt_s = $signed(rs_data) < $signed(op_b);
    assign lt_u = rs_data < op_b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_res = sum;
            ALU_SUB:  alu_res = rs_data - op_b;
            ALU_AND:  alu_res = rs_data & op_b;
            ALU_OR:   alu_res = rs_data | op_b;
            ALU_XOR:  alu_res = rs_data ^ op_b;
            ALU_NOR:  alu_res = ~(rs_data | op_b);
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, lt_u};
            ALU_LUI:  alu_res = {op_b[15:0], 16'h0000};
            default:  alu_res = sum;
        endcase
    end

    // Shifts operate on rt
    assign sh_amt = ctrl.shift_var ? rs_data[4:0] : sa;

    always_comb begin
        case (ctrl.shift_op)
            SH_SRL:  sh_res = rt_data >> sh_amt;
            SH_SRA:  sh_res = $signed(rt_data) >>> sh_amt;
            default: sh_res = rt_data << sh_amt;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:   wb_data = mem_rdata;
            WB_SHIFT: wb_data = sh_res;
            WB_LINK:  wb_data = pc_plus4;
            default:  wb_data = alu_res;
        endcase
    end

    assign mem_addr  = sum;
    assign mem_wdata = rt_data;

    // Only looked at when pc_sel is PC_BRANCH
    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   branch_taken = (rs_data == rt_data);
            BR_NE:   branch_taken = (rs_data != rt_data);
            BR_LEZ:  branch_taken = ($signed(rs_data) <= 0);
            BR_GTZ:  branch_taken = ($signed(rs_data) > 0);
            BR_LTZ:  branch_taken = rs_data[XLEN-1];
            BR_GEZ:  branch_taken = !rs_data[XLEN-1];
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// File: hdl/gp_regfile.sv
module gp_regfile
    import mips_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic [REG_AW-1:0] ra_addr,
    input  logic [REG_AW-1:0] rb_addr,
    output logic [XLEN-1:0]   ra_data,
    output logic [XLEN-1:0]   rb_data,
    input  logic [REG_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data,
    input  logic              wr_en
);

    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 is hardwired
    assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
    assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

// File: hdl/instr_decoder.sv
module instr_decoder
    import mips_pkg::*;
(
    input  instr_t            instr,
    output ctrl_t             ctrl,
    output logic [REG_AW-1:0] rs,
    output logic [REG_AW-1:0] rt
);

    typedef enum logic [1:0] {T_R, T_I, T_J} itype_e;

    function automatic itype_e instr_type(input opcode_e opc);
        case (opc)
            OP_RTYPE:     instr_type = T_R;
            OP_J, OP_JAL: instr_type = T_J;
            default:      instr_type = T_I;
        endcase
    endfunction

    assign rs = instr.r.rs;
    assign rt = instr.r.rt;

    always_comb begin
        ctrl.alu_op    = ALU_ADD;
        ctrl.use_imm   = 1'b0;
        ctrl.imm_ext   = IMM_SIGN;
        ctrl.shift_op  = SH_SLL;
        ctrl.shift_var = 1'b0;
        ctrl.gp_we     = 1'b0;
        ctrl.wb_sel    = WB_ALU;
        ctrl.br_cond   = BR_EQ;
        ctrl.pc_sel    = PC_SEQ;
        ctrl.mem_wren  = 1'b0;

        case (instr_type(instr.r.opc))
            T_R:     ctrl.dest = instr.r.rd;
            T_I:     ctrl.dest = instr.i.rt;
            default: ctrl.dest = LINK_REG; // Only jal writes it
        endcase

        case (instr.r.opc)
            OP_RTYPE: begin
                ctrl.gp_we = 1'b1;
                case (instr.r.fun)
                    FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD; // No overflow trap
                    FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:          ctrl.alu_op = ALU_AND;
                    FN_OR:           ctrl.alu_op = ALU_OR;
                    FN_XOR:          ctrl.alu_op = ALU_XOR;
                    FN_NOR:          ctrl.alu_op = ALU_NOR;
                    FN_SLT:          ctrl.alu_op = ALU_SLT;
                    FN_SLTU:         ctrl.alu_op = ALU_SLTU;
                    FN_SLL, FN_SLLV: begin
                        ctrl.wb_sel    = WB_SHIFT;
                        ctrl.shift_op  = SH_SLL;
                        ctrl.shift_var = instr.r.fun[2]; // Variable forms have bit 2 set
                    end
                    FN_SRL, FN_SRLV: begin
                        ctrl.wb_sel    = WB_SHIFT;
                        ctrl.shift_op  = SH_SRL;
                        ctrl.shift_var = instr.r.fun[2];
                    end
                    FN_SRA, FN_SRAV: begin
                        ctrl.wb_sel    = WB_SHIFT;
                        ctrl.shift_op  = SH_SRA;
                        ctrl.shift_var = instr.r.fun[2];
                    end
                    FN_JR: begin
                        ctrl.gp_we  = 1'b0;
                        ctrl.pc_sel = PC_REG;
                    end
                    FN_JALR: begin
                        ctrl.wb_sel = WB_LINK;
                        ctrl.pc_sel = PC_REG;
                    end
                    default: ctrl.gp_we = 1'b0; // Unsupported funct
                endcase
            end
            OP_REGIMM: begin
                ctrl.pc_sel  = PC_BRANCH;
                ctrl.br_cond = instr.i.rt[0] ? BR_GEZ : BR_LTZ;
            end
            OP_J: ctrl.pc_sel = PC_JUMP;
            OP_JAL: begin
                ctrl.pc_sel = PC_JUMP;
                ctrl.wb_sel = WB_LINK;
                ctrl.gp_we  = 1'b1;
            end
            OP_BEQ: begin
                ctrl.pc_sel  = PC_BRANCH;
                ctrl.br_cond = BR_EQ;
            end
            OP_BNE: begin
                ctrl.pc_sel  = PC_BRANCH;
                ctrl.br_cond = BR_NE;
            end
            OP_BLEZ: begin
                ctrl.pc_sel  = PC_BRANCH;
                ctrl.br_cond = BR_LEZ;
            end
            OP_BGTZ: begin
                ctrl.pc_sel  = PC_BRANCH;
                ctrl.br_cond = BR_GTZ;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.use_imm = 1'b1;
                ctrl.gp_we   = 1'b1;
                case (instr.i.opc)
                    OP_SLTI:  ctrl.alu_op = ALU_SLT;
                    OP_SLTIU: ctrl.alu_op = ALU_SLTU; // Sign-extended, compared unsigned
                    OP_ANDI: begin
                        ctrl.alu_op  = ALU_AND;
                        ctrl.imm_ext = IMM_ZERO;
                    end
                    OP_ORI: begin
                        ctrl.alu_op  = ALU_OR;
                        ctrl.imm_ext = IMM_ZERO;
                    end
                    OP_XORI: begin
                        ctrl.alu_op  = ALU_XOR;
                        ctrl.imm_ext = IMM_ZERO;
                    end
                    OP_LUI:  ctrl.alu_op = ALU_LUI;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                ctrl.use_imm = 1'b1;
                ctrl.gp_we   = 1'b1;
                ctrl.wb_sel  = WB_MEM;
            end
            OP_SW: begin
                ctrl.use_imm  = 1'b1;
                ctrl.mem_wren = 1'b1;
            end
            default: ; // No-op
        endcase
    end

endmodule

// File: hdl/mips_core.sv
module mips_core
    import mips_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    output logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] instr,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] mem_wdata,
    output logic            mem_wren,
    input  logic [XLEN-1:0] mem_rdata
);

    instr_t            ir;
    ctrl_t             ctrl;
    logic [REG_AW-1:0] rs_addr;
    logic [REG_AW-1:0] rt_addr;
    logic [XLEN-1:0]   rs_data;
    logic [XLEN-1:0]   rt_data;
    logic [XLEN-1:0]   wb_data;
    logic [XLEN-1:0]   pc_plus4;
    logic              branch_taken;

    assign ir       = instr;
    assign mem_wren = ctrl.mem_wren;

    instr_decoder i_decoder (
        .instr (ir),
        .ctrl  (ctrl),
        .rs    (rs_addr),
        .rt    (rt_addr)
    );

    gp_regfile i_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .ra_addr (rs_addr),
        .rb_addr (rt_addr),
        .ra_data (rs_data),
        .rb_data (rt_data),
        .wr_addr (ctrl.dest),
        .wr_data (wb_data),
        .wr_en   (ctrl.gp_we)
    );

    exec_unit i_exec (
        .ctrl         (ctrl),
        .imm          (ir.i.imm),
        .sa           (ir.r.sa),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .pc_plus4     (pc_plus4),
        .mem_rdata    (mem_rdata),
        .wb_data      (wb_data),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .branch_taken (branch_taken)
    );

    pc_unit i_pc (
        .clk          (clk),
        .arst_n       (arst_n),
        .pc_sel       (ctrl.pc_sel),
        .branch_taken (branch_taken),
        .imm          (ir.i.imm),
        .target       (ir.j.target),
        .rs_data      (rs_data),
        .pc           (pc),
        .pc_plus4     (pc_plus4)
    );

endmodule

// File: hdl/mips_pkg.sv
package mips_pkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [REG_AW-1:0] LINK_REG = 5'd31;

    typedef enum logic [5:0] {
        OP_RTYPE  = 6'b000000,
        OP_REGIMM = 6'b000001, // bltz/bgez, selected by rt[0]
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111,
        OP_ADDI   = 6'b001000,
        OP_ADDIU  = 6'b001001,
        OP_SLTI   = 6'b001010,
        OP_SLTIU  = 6'b001011,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111,
        OP_LW     = 6'b100011,
        OP_SW     = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SH_SLL, SH_SRL, SH_SRA} shift_op_e;

    typedef enum logic {IMM_SIGN, IMM_ZERO} imm_ext_e;

    typedef enum logic [1:0] {
        WB_ALU   = 2'b00,
        WB_MEM   = 2'b01,
        WB_SHIFT = 2'b10,
        WB_LINK  = 2'b11 // pc + 4
    } wb_sel_e;

    typedef enum logic [2:0] {BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ} br_cond_e;

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_e;

    // Three views of the same instruction word
    typedef struct packed {
        opcode_e           opc;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [4:0]        sa;
        funct_e            fun;
    } r_fmt_t;

    typedef struct packed {
        opcode_e           opc;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [15:0]       imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_e     opc;
        logic [25:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_t;

    typedef struct packed {
        alu_op_e           alu_op;
        logic              use_imm; // Immediate as second ALU operand
        imm_ext_e          imm_ext;
        shift_op_e         shift_op;
        logic              shift_var; // Amount from rs
        logic [REG_AW-1:0] dest;
        logic              gp_we;
        wb_sel_e           wb_sel;
        br_cond_e          br_cond;
        pc_sel_e           pc_sel;
        logic              mem_wren;
    } ctrl_t;

endpackage

// File: hdl/pc_unit.sv
module pc_unit
    import mips_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  pc_sel_e         pc_sel,
    input  logic            branch_taken,
    input  logic [15:0]     imm,
    input  logic [25:0]     target,
    input  logic [XLEN-1:0] rs_data,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] pc_plus4
);

    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] jmp_target;
    logic [XLEN-1:0] pc_next;

    assign pc_plus4 = pc + XLEN'(4);

    // Word offset, relative to the following instruction
    assign br_target = pc_plus4 + {{(XLEN-18){imm[15]}}, imm, 2'b00};

    // Stays inside the current 256 MB region
    assign jmp_target = {pc_plus4[XLEN-1:XLEN-4], target, 2'b00};

    always_comb begin
        case (pc_sel)
            PC_BRANCH: pc_next = branch_taken ? br_target : pc_plus4;
            PC_JUMP:   pc_next = jmp_target;
            PC_REG:    pc_next = rs_data;
            default:   pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: sources.f
hdl/mips_pkg.sv
hdl/instr_decoder.sv
hdl/gp_regfile.sv
hdl/exec_unit.sv
hdl/pc_unit.sv
hdl/mips_core.sv
dv/core_tb.sv
